/* hdl/profibus_phy_pkg.sv */
// Character level definitions shared by the UART blocks and the sequencer
package profibus_phy_pkg;

  // Clock cycles per bit, kept short for simulation
  localparam int bit_cycles = 8;

  // Start, eight data bits, even parity, stop
  localparam int char_bits = 11;

  // Payload of one character
  typedef logic [7:0] pb_byte_t;

  // Bit index within a character, or cycle count within a bit
  typedef logic [3:0] bit_cnt_t;

endpackage

/* hdl/profibus_fdl_pkg.sv */
// Telegram level definitions for the FDL sequencer and its register map
package profibus_fdl_pkg;

  localparam profibus_phy_pkg::pb_byte_t sd1         = 8'h10;
  localparam profibus_phy_pkg::pb_byte_t ed          = 8'h16;
  localparam profibus_phy_pkg::pb_byte_t short_ack   = 8'hE5;
  localparam profibus_phy_pkg::pb_byte_t master_addr = 8'h02;

  // Longest gap from end of request to start bit of the reply
  localparam int slot_cycles = 100 * profibus_phy_pkg::bit_cycles;

  typedef logic [9:0] slot_cnt_t;

  typedef enum logic [2:0] {
    err_none,
    err_timeout,
    err_parity,
    err_framing,   // Stop bit read as 0
    err_delimiter,
    err_address,
    err_fcs
  } pb_err_t;

  typedef enum logic [2:0] {
    idle,
    send,
    wait_slot,
    receive,
    finish
  } master_state_t;

  typedef logic [3:0] axil_addr_t;

  localparam axil_addr_t reg_ctrl   = 4'h0;
  localparam axil_addr_t reg_req    = 4'h4;
  localparam axil_addr_t reg_status = 4'h8;
  localparam axil_addr_t reg_resp   = 4'hC;

endpackage

/* hdl/profibus_uart_tx.sv */
module profibus_uart_tx (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      tx_valid,
  input  profibus_phy_pkg::pb_byte_t tx_byte,
  output logic                      tx_ready,
  output logic                      txd
);

  import profibus_phy_pkg::*;

  logic [char_bits-1:0] shreg;   // Bit 0 is on the line
  logic                 active;
  bit_cnt_t             cyc_cnt;
  bit_cnt_t             bit_idx;

  assign txd = shreg[0];

  always_ff @(posedge clk) begin
    if (reset) begin
      shreg    <= '1;            // Line idles high
      active   <= 1'b0;
      tx_ready <= 1'b0;
      cyc_cnt  <= '0;
      bit_idx  <= '0;
    end else if (!active) begin
      tx_ready <= 1'b1;
      if (tx_ready && tx_valid) begin
        // Stop, even parity, data LSB first, start
        shreg    <= {1'b1, ^tx_byte, tx_byte, 1'b0};
        active   <= 1'b1;
        tx_ready <= 1'b0;
        cyc_cnt  <= '0;
        bit_idx  <= '0;
      end
    end else if (cyc_cnt == bit_cnt_t'(bit_cycles - 1)) begin
      cyc_cnt <= '0;
      shreg   <= {1'b1, shreg[char_bits-1:1]};
      if (bit_idx == bit_cnt_t'(char_bits - 1)) begin
        // End of stop bit
        active   <= 1'b0;
        tx_ready <= 1'b1;
      end else begin
        bit_idx <= bit_idx + 1'b1;
      end
    end else begin
      cyc_cnt <= cyc_cnt + 1'b1;
    end
  end

endmodule

/* hdl/profibus_uart_rx.sv */
module profibus_uart_rx (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       rxd,
  output logic                       rx_valid,
  output profibus_phy_pkg::pb_byte_t rx_byte,
  output logic                       rx_parity_err,
  output logic                       rx_stop_err
);

  import profibus_phy_pkg::*;

  logic       rxd_meta;
  logic       rxd_sync;
  logic       rxd_prev;
  logic       active;
  logic       sample;
  bit_cnt_t   cyc_cnt;
  bit_cnt_t   bit_idx;
  logic [8:0] shreg;      // Data then parity, shifted in LSB first

  assign rx_byte = shreg[7:0];
  assign sample  = active && (cyc_cnt == '0);

  // Two flop synchronizer plus edge history
  always_ff @(posedge clk) begin
    if (reset) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      active   <= 1'b0;
      rx_valid <= 1'b0;
      cyc_cnt  <= '0;
      bit_idx  <= '0;
    end else begin
      rx_valid <= 1'b0;
      if (!active) begin
        if (rxd_prev && !rxd_sync) begin
          active  <= 1'b1;
          cyc_cnt <= bit_cnt_t'(bit_cycles / 2 - 1);   // Half bit to mid start bit
          bit_idx <= '0;
        end
      end else if (!sample) begin
        cyc_cnt <= cyc_cnt - 1'b1;
      end else begin
        cyc_cnt <= bit_cnt_t'(bit_cycles - 1);
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx == '0 && rxd_sync) begin
          active <= 1'b0;                  // Glitch, not a start bit
        end else if (bit_idx == bit_cnt_t'(char_bits - 1)) begin
          active   <= 1'b0;
          rx_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample && bit_idx != '0 && bit_idx != bit_cnt_t'(char_bits - 1)) begin
      shreg <= {rxd_sync, shreg[8:1]};
    end
    if (sample && bit_idx == bit_cnt_t'(char_bits - 1)) begin
      rx_parity_err <= ^shreg;             // Even parity over data and parity bit
      rx_stop_err   <= !rxd_sync;
    end
  end

endmodule

/* hdl/profibus_master.sv */
module profibus_master (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  profibus_phy_pkg::pb_byte_t req_da,
  input  profibus_phy_pkg::pb_byte_t req_fc,
  output logic                       busy,
  output logic                       done_pulse,
  output profibus_fdl_pkg::pb_err_t  err,
  output profibus_phy_pkg::pb_byte_t resp_fc,
  output profibus_phy_pkg::pb_byte_t resp_sa,
  output logic                       resp_short,
  output logic                       tx_valid,
  output profibus_phy_pkg::pb_byte_t tx_byte,
  input  logic                       tx_ready,
  output logic                       tx_enable,
  input  logic                       rx_valid,
  input  profibus_phy_pkg::pb_byte_t rx_byte,
  input  logic                       rx_parity_err,
  input  logic                       rx_stop_err
);

  import profibus_phy_pkg::*;
  import profibus_fdl_pkg::*;

  master_state_t state;
  logic [2:0]    char_idx;   // Position in the request or the reply
  pb_byte_t      fcs;
  slot_cnt_t     slot_cnt;
  pb_err_t       rx_err;
  logic          rx_last;

  assign busy       = (state != idle) && (state != finish);
  assign done_pulse = (state == finish);
  assign tx_valid   = (state == send) && (char_idx != 3'd6);

  always_comb begin
    case (char_idx)
      3'd0:    tx_byte = sd1;
      3'd1:    tx_byte = req_da;
      3'd2:    tx_byte = master_addr;
      3'd3:    tx_byte = req_fc;
      3'd4:    tx_byte = fcs;
      default: tx_byte = ed;
    endcase
  end

  // Check of one reply character against its position
  always_comb begin
    rx_err  = err_none;
    rx_last = 1'b0;
    if (rx_parity_err) begin
      rx_err = err_parity;
    end else if (rx_stop_err) begin
      rx_err = err_framing;
    end else begin
      case (char_idx)
        3'd0: begin
          if (rx_byte == short_ack) rx_last = 1'b1;
          else if (rx_byte != sd1) rx_err = err_delimiter;
        end
        3'd1: if (rx_byte != master_addr) rx_err = err_address;
        3'd4: if (rx_byte != fcs) rx_err = err_fcs;
        3'd5: begin
          rx_last = 1'b1;
          if (rx_byte != ed) rx_err = err_delimiter;
        end
        default: rx_last = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= idle;
      tx_enable  <= 1'b0;
      err        <= err_none;
      resp_short <= 1'b0;
      char_idx   <= '0;
      fcs        <= '0;
      slot_cnt   <= '0;
    end else begin
      case (state)
        idle, finish: begin
          state <= idle;
          if (start) begin
            state      <= send;
            tx_enable  <= 1'b1;
            char_idx   <= '0;
            fcs        <= '0;
            err        <= err_none;
            resp_short <= 1'b0;
            resp_fc    <= '0;
            resp_sa    <= '0;
          end
        end
        send: begin
          if (tx_valid && tx_ready) begin
            char_idx <= char_idx + 1'b1;
            if (char_idx >= 3'd1 && char_idx <= 3'd3) fcs <= fcs + tx_byte;
          end else if (char_idx == 3'd6 && tx_ready) begin
            tx_enable <= 1'b0;              // Last stop bit is out
            state     <= wait_slot;
            slot_cnt  <= '0;
            char_idx  <= '0;
            fcs       <= '0;
          end
        end
        wait_slot, receive: begin
          if (state == wait_slot) slot_cnt <= slot_cnt + 1'b1;
          if (rx_valid) begin
            state    <= receive;
            char_idx <= char_idx + 1'b1;
            if (char_idx == 3'd0) resp_short <= rx_last;
            if (char_idx == 3'd2) resp_sa <= rx_byte;
            if (char_idx == 3'd3) resp_fc <= rx_byte;
            if (char_idx >= 3'd1 && char_idx <= 3'd3) fcs <= fcs + rx_byte;
            if (rx_err != err_none) begin
              err   <= rx_err;
              state <= finish;
            end else if (rx_last) begin
              state <= finish;
            end
          end else if (state == wait_slot &&
                       slot_cnt == slot_cnt_t'(slot_cycles + char_bits * bit_cycles)) begin
            // rx_valid trails the reply start bit by one character
            err   <= err_timeout;
            state <= finish;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

/* hdl/profibus_axil_regs.sv */
module profibus_axil_regs (
  input  logic                         clk,
  input  logic                         reset,
  input  profibus_fdl_pkg::axil_addr_t awaddr,
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [31:0]                  wdata,
  input  logic [3:0]                   wstrb,
  input  logic                         wvalid,
  output logic                         wready,
  output logic [1:0]                   bresp,
  output logic                         bvalid,
  input  logic                         bready,
  input  profibus_fdl_pkg::axil_addr_t araddr,
  input  logic                         arvalid,
  output logic                         arready,
  output logic [31:0]                  rdata,
  output logic [1:0]                   rresp,
  output logic                         rvalid,
  input  logic                         rready,
  output logic                         start,
  output profibus_phy_pkg::pb_byte_t   req_da,
  output profibus_phy_pkg::pb_byte_t   req_fc,
  input  logic                         busy,
  input  logic                         done_pulse,
  input  profibus_fdl_pkg::pb_err_t    err,
  input  profibus_phy_pkg::pb_byte_t   resp_fc,
  input  profibus_phy_pkg::pb_byte_t   resp_sa,
  input  logic                         resp_short
);

  import profibus_phy_pkg::*;
  import profibus_fdl_pkg::*;

  axil_addr_t  wr_addr;
  logic [31:0] wdata_q;
  logic [3:0]  wstrb_q;
  logic        aw_held;
  logic        w_held;
  logic        done;
  pb_err_t     err_q;
  pb_byte_t    fc_q;
  pb_byte_t    sa_q;
  logic        short_q;

  assign bresp = 2'b00;
  assign rresp = 2'b00;

  always_ff @(posedge clk) begin
    if (reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      start   <= 1'b0;
      req_da  <= '0;
      req_fc  <= '0;
      done    <= 1'b0;
      err_q   <= err_none;
      fc_q    <= '0;
      sa_q    <= '0;
      short_q <= 1'b0;
    end else begin
      start <= 1'b0;
      if (awready && awvalid) begin
        wr_addr <= awaddr;
        aw_held <= 1'b1;
        awready <= 1'b0;
      end else if (!aw_held) begin
        awready <= 1'b1;
      end
      if (wready && wvalid) begin
        wdata_q <= wdata;
        wstrb_q <= wstrb;
        w_held  <= 1'b1;
        wready  <= 1'b0;
      end else if (!w_held) begin
        wready <= 1'b1;
      end
      if (bvalid && bready) bvalid <= 1'b0;

      // Reply fields follow the sequencer at the end of a transfer
      if (done_pulse) begin
        done    <= 1'b1;
        err_q   <= err;
        fc_q    <= resp_fc;
        sa_q    <= resp_sa;
        short_q <= resp_short;
      end

      if (aw_held && w_held && !bvalid) begin
        aw_held <= 1'b0;
        w_held  <= 1'b0;
        bvalid  <= 1'b1;
        case (wr_addr)
          reg_ctrl: begin
            if (wstrb_q[0] && wdata_q[0] && !busy && !start) begin
              start <= 1'b1;
              done  <= 1'b0;
              err_q <= err_none;
            end
          end
          reg_req: begin
            if (wstrb_q[0]) req_da <= wdata_q[7:0];
            if (wstrb_q[1]) req_fc <= wdata_q[15:8];
          end
          default: ;
        endcase
      end

      if (arready && arvalid) begin
        arready <= 1'b0;
        rvalid  <= 1'b1;
        case (araddr)
          reg_req:    rdata <= {16'h0, req_fc, req_da};
          reg_status: rdata <= {27'h0, err_q, done, busy || start};
          reg_resp:   rdata <= {15'h0, short_q, sa_q, fc_q};
          default:    rdata <= '0;
        endcase
      end else if (rvalid && rready) begin
        rvalid  <= 1'b0;
        arready <= 1'b1;
      end else if (!rvalid) begin
        arready <= 1'b1;
      end
    end
  end

endmodule

/* hdl/profibus_top.sv */
module profibus_top (
  input  logic                         clk,
  input  logic                         reset,
  input  profibus_fdl_pkg::axil_addr_t awaddr,
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [31:0]                  wdata,
  input  logic [3:0]                   wstrb,
  input  logic                         wvalid,
  output logic                         wready,
  output logic [1:0]                   bresp,
  output logic                         bvalid,
  input  logic                         bready,
  input  profibus_fdl_pkg::axil_addr_t araddr,
  input  logic                         arvalid,
  output logic                         arready,
  output logic [31:0]                  rdata,
  output logic [1:0]                   rresp,
  output logic                         rvalid,
  input  logic                         rready,
  output logic                         txd,
  output logic                         tx_enable,
  input  logic                         rxd
);

  import profibus_phy_pkg::*;
  import profibus_fdl_pkg::*;

  logic     start;
  pb_byte_t req_da;
  pb_byte_t req_fc;
  logic     busy;
  logic     done_pulse;
  pb_err_t  err;
  pb_byte_t resp_fc;
  pb_byte_t resp_sa;
  logic     resp_short;
  logic     tx_valid;
  pb_byte_t tx_byte;
  logic     tx_ready;
  logic     rx_valid;
  pb_byte_t rx_byte;
  logic     rx_parity_err;
  logic     rx_stop_err;

  profibus_axil_regs regs0 (
    .clk(clk), .reset(reset),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .start(start), .req_da(req_da), .req_fc(req_fc),
    .busy(busy), .done_pulse(done_pulse), .err(err),
    .resp_fc(resp_fc), .resp_sa(resp_sa), .resp_short(resp_short)
  );

  profibus_master master0 (
    .clk(clk), .reset(reset),
    .start(start), .req_da(req_da), .req_fc(req_fc),
    .busy(busy), .done_pulse(done_pulse), .err(err),
    .resp_fc(resp_fc), .resp_sa(resp_sa), .resp_short(resp_short),
    .tx_valid(tx_valid), .tx_byte(tx_byte), .tx_ready(tx_ready),
    .tx_enable(tx_enable),
    .rx_valid(rx_valid), .rx_byte(rx_byte),
    .rx_parity_err(rx_parity_err), .rx_stop_err(rx_stop_err)
  );

  profibus_uart_tx uart_tx0 (
    .clk(clk), .reset(reset),
    .tx_valid(tx_valid), .tx_byte(tx_byte), .tx_ready(tx_ready),
    .txd(txd)
  );

  profibus_uart_rx uart_rx0 (
    .clk(clk), .reset(reset), .rxd(rxd),
    .rx_valid(rx_valid), .rx_byte(rx_byte),
    .rx_parity_err(rx_parity_err), .rx_stop_err(rx_stop_err)
  );

endmodule

/* test/profibus_reply_kinds.svh */
localparam logic [3:0] kind_full       = 4'd0;
localparam logic [3:0] kind_short      = 4'd1;   // Short acknowledge only
localparam logic [3:0] kind_none       = 4'd2;   // Slave stays silent
localparam logic [3:0] kind_bad_parity = 4'd3;
localparam logic [3:0] kind_bad_stop   = 4'd4;
localparam logic [3:0] kind_bad_fcs    = 4'd5;
localparam logic [3:0] kind_wrong_da   = 4'd6;
localparam logic [3:0] kind_bad_ed     = 4'd7;
localparam logic [3:0] kind_bad_sd     = 4'd8;   // First character is not a known SD

/* test/profibus_slave_model.sv */
module profibus_slave_model (
  input  logic                       clk,
  input  logic                       txd,
  input  logic                       tx_enable,
  output logic                       rxd,
  input  logic [3:0]                 reply_kind,
  input  profibus_phy_pkg::pb_byte_t reply_fc,
  input  profibus_phy_pkg::pb_byte_t reply_sa,
  output profibus_phy_pkg::pb_byte_t req_chars [6],
  output logic                       frame_ok,
  output logic                       idle,
  output int                         char_count,
  output logic                       fault
);

  timeunit 1ns;
  timeprecision 1ps;

  import profibus_phy_pkg::*;
  import profibus_fdl_pkg::*;

  `include "profibus_reply_kinds.svh"

  localparam int seed          = 71173;
  localparam int request_limit = 20000;            // Cycles until the first start bit
  localparam int gap_limit     = 4 * bit_cycles;   // Cycles between request characters

  logic [16:0] lfsr;
  logic        chars_ok;

  // Taps for x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_step(input logic [16:0] state);
    return {state[15:0], state[16] ^ state[13]};
  endfunction

  task automatic report_fault(input string reason);
    $display("slave model: %s at %0t", reason, $time);
    fault = 1'b1;
  endtask

  // Find the start bit, then sample each bit in its middle
  task automatic take_char(input logic first, output pb_byte_t data);
    logic [char_bits-1:0] bits;
    int                   cycles;
    cycles = 0;
    while (!(txd === 1'b0 && (tx_enable === 1'b1 || !first))) begin
      @(negedge clk);
      cycles++;
      if (!first && tx_enable !== 1'b1) chars_ok = 1'b0;   // Driver dropped between chars
      if (cycles > (first ? request_limit : gap_limit)) begin
        report_fault("no start bit on txd");
        break;
      end
    end
    repeat (bit_cycles / 2 - 1) @(negedge clk);
    for (int i = 0; i < char_bits; i++) begin
      if (i != 0) repeat (bit_cycles) @(negedge clk);
      bits[i] = txd;
      if (tx_enable !== 1'b1) chars_ok = 1'b0;
    end
    data = bits[8:1];
    if (bits[0] !== 1'b0 || ^bits[9:1] !== 1'b0 || bits[10] !== 1'b1) chars_ok = 1'b0;
    char_count++;
  endtask

  task automatic send_char(input pb_byte_t data, input logic flip_parity, input logic stop_bit);
    logic [char_bits-1:0] bits;
    bits = {stop_bit, (^data) ^ flip_parity, data, 1'b0};
    for (int i = 0; i < char_bits; i++) begin
      rxd = bits[i];
      repeat (bit_cycles) @(negedge clk);
    end
  endtask

  initial begin
    pb_byte_t data;
    pb_byte_t fcs;
    pb_byte_t reply [6];
    int       n_reply;
    int       bad_parity_idx;
    int       bad_stop_idx;
    int       delay;
    int       cycles;
    rxd        = 1'b1;
    idle       = 1'b1;
    fault      = 1'b0;
    frame_ok   = 1'b0;
    chars_ok   = 1'b1;
    char_count = 0;
    lfsr       = 17'(seed);
    for (int i = 0; i < 6; i++) req_chars[i] = '0;
    forever begin
      chars_ok = 1'b1;
      for (int i = 0; i < 6; i++) begin
        take_char(i == 0, data);
        req_chars[i] = data;
        idle = 1'b0;
      end
      frame_ok = chars_ok;

      cycles = 0;
      while (tx_enable === 1'b1) begin
        @(negedge clk);
        cycles++;
        if (cycles > gap_limit) begin
          report_fault("tx_enable stays high after the last stop bit");
          break;
        end
      end

      // Turnaround of 0 to 63 bit times, well inside the slot time
      delay = 0;
      for (int i = 0; i < 6; i++) begin
        lfsr  = lfsr_step(lfsr);
        delay = (delay << 1) | int'(lfsr[0]);
      end
      repeat (delay * bit_cycles) @(negedge clk);

      fcs            = master_addr + reply_sa + reply_fc;
      reply          = '{sd1, master_addr, reply_sa, reply_fc, fcs, ed};
      n_reply        = 6;
      bad_parity_idx = -1;
      bad_stop_idx   = -1;
      case (reply_kind)
        kind_short: begin
          reply[0] = short_ack;
          n_reply  = 1;
        end
        kind_bad_sd: begin
          reply[0] = 8'h68;              // SD2, not handled by the master
          n_reply  = 1;
        end
        kind_none:       n_reply = 0;
        kind_bad_parity: bad_parity_idx = 2;
        kind_bad_stop:   bad_stop_idx = 5;
        kind_bad_fcs:    reply[4] = fcs + 8'h01;
        kind_wrong_da:   reply[1] = master_addr + 8'h01;
        kind_bad_ed:     reply[5] = ed + 8'h01;
        default:         n_reply = 6;
      endcase
      for (int i = 0; i < n_reply; i++) begin
        send_char(reply[i], i == bad_parity_idx, i != bad_stop_idx);
      end
      rxd  = 1'b1;
      idle = 1'b1;
    end
  end

endmodule

/* test/profibus_tb.sv */
module profibus_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import profibus_phy_pkg::*;
  import profibus_fdl_pkg::*;

  `include "profibus_reply_kinds.svh"

  localparam int n_entries    = 10;
  localparam int hs_limit     = 50;     // Cycles for one AXI handshake
  localparam int poll_limit   = 2000;   // Status reads while waiting for done
  localparam int idle_limit   = 2000;   // Cycles for the slave model to go quiet
  localparam int quiet_cycles = 2 * char_bits * bit_cycles;   // A second telegram shows up here

  typedef struct packed {
    pb_byte_t   da;
    pb_byte_t   fc;
    logic [3:0] kind;
    pb_byte_t   rsp_fc;
    pb_byte_t   rsp_sa;
    pb_err_t    exp_err;
  } entry_t;

  logic        clk;
  logic        reset;
  axil_addr_t  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  axil_addr_t  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic        txd;
  logic        tx_enable;
  logic        rxd;

  logic [3:0]  reply_kind;
  pb_byte_t    reply_fc;
  pb_byte_t    reply_sa;
  pb_byte_t    req_chars [6];
  logic        frame_ok;
  logic        slave_idle;
  int          char_count;
  logic        slave_fault;

  entry_t      entries [n_entries];

  profibus_top dut0 (
    .clk(clk), .reset(reset),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .txd(txd), .tx_enable(tx_enable), .rxd(rxd)
  );

  profibus_slave_model slave0 (
    .clk(clk), .txd(txd), .tx_enable(tx_enable), .rxd(rxd),
    .reply_kind(reply_kind), .reply_fc(reply_fc), .reply_sa(reply_sa),
    .req_chars(req_chars), .frame_ok(frame_ok), .idle(slave_idle),
    .char_count(char_count), .fault(slave_fault)
  );

  always #10 clk = ~clk;

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  always @(negedge clk) begin
    if (slave_fault) begin
      $display("slave model lost track of the line");
      abort_run();
    end
  end

  task automatic check_byte(input string name, input pb_byte_t got, input pb_byte_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_err(input string name, input pb_err_t got, input pb_err_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic axil_write(input axil_addr_t addr, input logic [31:0] data);
    int   cycles;
    logic aw_done;
    logic w_done;
    cycles  = 0;
    aw_done = 1'b0;
    w_done  = 1'b0;
    @(negedge clk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = 4'hF;
    wvalid  = 1'b1;
    while (awvalid || wvalid) begin
      if (awready) aw_done = 1'b1;   // Taken at the coming rising edge
      if (wready) w_done = 1'b1;
      @(negedge clk);
      if (aw_done) awvalid = 1'b0;
      if (w_done) wvalid = 1'b0;
      cycles++;
      if (cycles > hs_limit) begin
        $display("AXI write to %h never saw awready and wready", addr);
        abort_run();
      end
    end
    cycles = 0;
    while (!bvalid) begin
      @(negedge clk);
      cycles++;
      if (cycles > hs_limit) begin
        $display("AXI write to %h got no write response", addr);
        abort_run();
      end
    end
    check_bit("bresp[1]", bresp[1], 1'b0);
    check_bit("bresp[0]", bresp[0], 1'b0);
  endtask

  task automatic axil_read(input axil_addr_t addr, output logic [31:0] data);
    int cycles;
    cycles = 0;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) begin
      @(negedge clk);
      cycles++;
      if (cycles > hs_limit) begin
        $display("AXI read of %h never saw arready", addr);
        abort_run();
      end
    end
    @(negedge clk);
    arvalid = 1'b0;
    cycles  = 0;
    while (!rvalid) begin
      @(negedge clk);
      cycles++;
      if (cycles > hs_limit) begin
        $display("AXI read of %h returned no data", addr);
        abort_run();
      end
    end
    check_bit("rresp[1]", rresp[1], 1'b0);
    check_bit("rresp[0]", rresp[0], 1'b0);
    data = rdata;
  endtask

  initial begin
    logic [31:0] data;
    entry_t      e;
    int          count_before;
    int          polls;
    int          cycles;
    clk        = 1'b0;
    reset      = 1'b1;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b1;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b1;
    reply_kind = kind_none;
    reply_fc   = '0;
    reply_sa   = '0;
    // DA, FC, reply kind, reply FC, reply SA, expected error
    entries = '{
      '{8'h05, 8'h6D, kind_full,       8'h08, 8'h05, err_none},
      '{8'h21, 8'h5D, kind_short,      8'h00, 8'h00, err_none},
      '{8'h07, 8'h4C, kind_none,       8'h00, 8'h00, err_timeout},
      '{8'h05, 8'h7D, kind_bad_parity, 8'h08, 8'h05, err_parity},
      '{8'h12, 8'h6C, kind_bad_stop,   8'h08, 8'h12, err_framing},
      '{8'h05, 8'h5D, kind_bad_ed,     8'h08, 8'h05, err_delimiter},
      '{8'h33, 8'h4D, kind_bad_sd,     8'h00, 8'h00, err_delimiter},
      '{8'h05, 8'h6D, kind_wrong_da,   8'h08, 8'h05, err_address},
      '{8'h7E, 8'h5C, kind_bad_fcs,    8'h0A, 8'h7E, err_fcs},
      '{8'hF0, 8'h49, kind_full,       8'hC8, 8'hF0, err_none}   // Both checksums wrap
    };
    repeat (5) @(negedge clk);
    reset = 1'b0;
    check_bit("txd after reset", txd, 1'b1);
    check_bit("tx_enable after reset", tx_enable, 1'b0);
    axil_read(reg_status, data);
    check_bit("status busy after reset", data[0], 1'b0);
    check_bit("status done after reset", data[1], 1'b0);
    check_err("status err after reset", pb_err_t'(data[4:2]), err_none);

    for (int i = 0; i < n_entries; i++) begin
      e          = entries[i];
      reply_kind = e.kind;
      reply_fc   = e.rsp_fc;
      reply_sa   = e.rsp_sa;
      axil_write(reg_req, {16'h0, e.fc, e.da});
      axil_read(reg_req, data);
      check_byte("reg_req da", data[7:0], e.da);
      check_byte("reg_req fc", data[15:8], e.fc);

      count_before = char_count;
      axil_write(reg_ctrl, 32'h1);
      axil_read(reg_status, data);
      check_bit("busy after start", data[0], 1'b1);
      axil_write(reg_ctrl, 32'h1);   // Second start while busy

      polls = 0;
      do begin
        axil_read(reg_status, data);
        polls++;
        if (polls > poll_limit) begin
          $display("done never set for table entry %0d", i);
          abort_run();
        end
      end while (!data[1]);
      check_bit("busy at done", data[0], 1'b0);
      check_err("status err", pb_err_t'(data[4:2]), e.exp_err);

      if (e.exp_err == err_none) begin
        axil_read(reg_resp, data);
        check_byte("reply fc", data[7:0], e.rsp_fc);
        check_byte("reply sa", data[15:8], e.rsp_sa);
        check_bit("short flag", data[16], e.kind == kind_short);
      end

      cycles = 0;
      while (!slave_idle) begin
        @(negedge clk);
        cycles++;
        if (cycles > idle_limit) begin
          $display("slave model still sending long after done");
          abort_run();
        end
      end
      check_byte("request sd", req_chars[0], sd1);
      check_byte("request da", req_chars[1], e.da);
      check_byte("request sa", req_chars[2], master_addr);
      check_byte("request fc", req_chars[3], e.fc);
      check_byte("request fcs", req_chars[4], e.da + master_addr + e.fc);
      check_byte("request ed", req_chars[5], ed);
      check_bit("request parity, stop and driver enable", frame_ok, 1'b1);

      // The line stays quiet after the reply
      cycles = 0;
      while (cycles < quiet_cycles) begin
        @(negedge clk);
        cycles++;
        check_bit("tx_enable after done", tx_enable, 1'b0);
      end
      if (char_count != count_before + 6) begin
        $display("mismatch at %0t: char_count is %0d, expected %0d", $time, char_count,
                 count_before + 6);
        abort_run();
      end
    end

    $display("Test OK");
    $finish;
  end

endmodule

/* sim.f */
+incdir+test
hdl/profibus_phy_pkg.sv
hdl/profibus_fdl_pkg.sv
hdl/profibus_uart_tx.sv
hdl/profibus_uart_rx.sv
hdl/profibus_master.sv
hdl/profibus_axil_regs.sv
hdl/profibus_top.sv
test/profibus_slave_model.sv
test/profibus_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= profibus_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
